// File: common/alu_pkg.sv
package alu_pkg;

    // Datapath definitions shared by the ALU, register file and pipeline

    // Data width of the machine
    localparam int unsigned XLEN = 16;

    // Shift amount taken from the low bits of b
    localparam int unsigned SHAMT_W = $clog2(XLEN);

    // Register index carried by a result record
    // Three bits, so at most eight registers
    typedef logic [2:0] rd_idx_t;

    // Status flags
    // Bit order V N C Z, so Z lands in bit 0
    typedef struct packed {
        logic v;    // Two's complement overflow
        logic n;    // Result sign
        logic c;    // Carry out, or borrow on subtract
        logic z;    // Result is zero
    } flags_t;

    // Writeback record leaving the execute stage
    // Feeds the register file write port and the forwarding path
    typedef struct packed {
        rd_idx_t           rd;
        logic              we;      // Commit data to rd
        logic [XLEN-1:0]   data;
        flags_t            flags;   // Flags produced by this result
    } wb_t;

endpackage

// File: common/isa_pkg.sv
package isa_pkg;

    // Opcodes, instruction word and issue record

    // Register index width, follows the result record
    localparam int unsigned REG_IDX_W = $bits(alu_pkg::rd_idx_t);

    // Opcodes, remaining codes decode as unknown
    typedef enum logic [3:0] {
        OP_ADD = 4'h0,  // a + b, carry flag ignored
        OP_ADC = 4'h1,  // a + b + C
        OP_SUB = 4'h2,  // a - b
        OP_CMP = 4'h3,  // a - b, flags only
        OP_SHL = 4'h4,  // a << b[3:0]
        OP_SHR = 4'h5,  // a >> b[3:0], logical
        OP_LDI = 4'h6   // pass b
    } opcode_e;

    // Instruction word as presented on the input
    typedef struct packed {
        opcode_e                   op;
        logic [REG_IDX_W-1:0]      rd;
        logic [REG_IDX_W-1:0]      rs1;
        logic [REG_IDX_W-1:0]      rs2;
        logic                      use_imm;    // b comes from imm, not rs2
        logic [alu_pkg::XLEN-1:0]  imm;
    } instr_t;

    // Issue record handed from operand fetch to execute
    // Operands already resolved, forwarding included
    typedef struct packed {
        opcode_e                   op;
        logic [REG_IDX_W-1:0]      rd;
        logic [alu_pkg::XLEN-1:0]  a;
        logic [alu_pkg::XLEN-1:0]  b;
        logic                      valid;
    } issue_t;

endpackage

// File: src/reg_file.sv
module reg_file #(
    parameter int unsigned REG_COUNT = 8
) (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  alu_pkg::wb_t                     wb_i,
    input  logic [isa_pkg::REG_IDX_W-1:0]    raddr_a_i,
    input  logic [isa_pkg::REG_IDX_W-1:0]    raddr_b_i,
    output logic [alu_pkg::XLEN-1:0]         rdata_a_o,
    output logic [alu_pkg::XLEN-1:0]         rdata_b_o
);
    import alu_pkg::*;
    import isa_pkg::*;

    logic [XLEN-1:0]      regs_q [REG_COUNT];
    logic [REG_IDX_W-1:0] raddr [2];
    logic [XLEN-1:0]      rdata [2];
    logic                 wr_en;

    // Writes above REG_COUNT are dropped
    assign wr_en = wb_i.we && (wb_i.rd < REG_COUNT);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en) begin
            regs_q[wb_i.rd] <= wb_i.data;
        end
    end

    // Both read ports share one path
    assign raddr[0] = raddr_a_i;
    assign raddr[1] = raddr_b_i;

    // Write before read: a port reading the register under write
    // sees the incoming data in the same cycle
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            if (wr_en && (wb_i.rd == raddr[p])) begin
                rdata[p] = wb_i.data;
            end else if (raddr[p] < REG_COUNT) begin
                rdata[p] = regs_q[raddr[p]];
            end else begin
                // Unimplemented register reads as zero
                rdata[p] = '0;
            end
        end
    end

    assign rdata_a_o = rdata[0];
    assign rdata_b_o = rdata[1];

endmodule

// File: src/operand_fetch.sv
module operand_fetch #(
    parameter int unsigned REG_COUNT = 8
) (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  logic                             instr_valid_i,
    input  isa_pkg::instr_t                  instr_i,
    output logic [isa_pkg::REG_IDX_W-1:0]    raddr_a_o,
    output logic [isa_pkg::REG_IDX_W-1:0]    raddr_b_o,
    input  logic [alu_pkg::XLEN-1:0]         rdata_a_i,
    input  logic [alu_pkg::XLEN-1:0]         rdata_b_i,
    input  alu_pkg::wb_t                     fwd_i,
    output isa_pkg::issue_t                  issue_o
);
    import alu_pkg::*;
    import isa_pkg::*;

    instr_t          instr_q;
    logic            valid_q;
    logic            fwd_a;
    logic            fwd_b;
    logic [XLEN-1:0] src_a;
    logic [XLEN-1:0] reg_b;
    logic [XLEN-1:0] src_b;

    // ------------------------------------------------------------------------
    // Capture
    // ------------------------------------------------------------------------

    // Accepted instruction held for one cycle
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= instr_valid_i;
        end
    end

    // Instruction fields, no reset
    always_ff @(posedge clk_i) begin
        if (instr_valid_i) begin
            instr_q <= instr_i;
        end
    end

    // ------------------------------------------------------------------------
    // Operand read and forwarding
    // ------------------------------------------------------------------------

    assign raddr_a_o = instr_q.rs1;
    assign raddr_b_o = instr_q.rs2;

    // Previous instruction sits in execute with its result registered
    // Its data has not reached the register file yet
    assign fwd_a = fwd_i.we && (fwd_i.rd == instr_q.rs1) && (instr_q.rs1 < REG_COUNT);
    assign fwd_b = fwd_i.we && (fwd_i.rd == instr_q.rs2) && (instr_q.rs2 < REG_COUNT);

    assign src_a = fwd_a ? fwd_i.data : rdata_a_i;
    assign reg_b = fwd_b ? fwd_i.data : rdata_b_i;

    // Immediate replaces rs2
    assign src_b = instr_q.use_imm ? instr_q.imm : reg_b;

    // Issue record toward execute
    assign issue_o = '{
        op:    instr_q.op,
        rd:    instr_q.rd,
        a:     src_a,
        b:     src_b,
        valid: valid_q
    };

endmodule

// File: alu/alu_core.sv
module alu_core (
    input  logic                        carry_i,
    input  isa_pkg::opcode_e            op_i,
    input  logic [alu_pkg::XLEN-1:0]    a_i,
    input  logic [alu_pkg::XLEN-1:0]    b_i,
    output logic [alu_pkg::XLEN-1:0]    y_o,
    output alu_pkg::flags_t             flags_o
);
    import alu_pkg::*;
    import isa_pkg::*;

    logic [XLEN:0]   carry_ext;
    logic [XLEN:0]   sum;
    logic [XLEN:0]   diff;
    logic [XLEN-1:0] res;
    logic            c_flag;
    logic            v_flag;
    logic            a_sign;
    logic            b_sign;
    logic            r_sign;

    // ------------------------------------------------------------------------
    // Adder and subtractor
    // ------------------------------------------------------------------------

    // Carry in widened to the adder width
    assign carry_ext = {{XLEN{1'b0}}, carry_i};

    // Only ADC consumes the carry flag
    assign sum  = {1'b0, a_i} + {1'b0, b_i} + ((op_i == OP_ADC) ? carry_ext : '0);

    // Top bit of the difference is the borrow
    assign diff = {1'b0, a_i} - {1'b0, b_i};

    assign a_sign = a_i[XLEN-1];
    assign b_sign = b_i[XLEN-1];
    assign r_sign = res[XLEN-1];

    // ------------------------------------------------------------------------
    // Result and carry per opcode
    // ------------------------------------------------------------------------
    always_comb begin
        res    = '0;
        c_flag = 1'b0;
        v_flag = 1'b0;

        case (op_i)
            OP_ADD, OP_ADC: begin
                {c_flag, res} = sum;
                // Like signs in, other sign out
                v_flag = (a_sign == b_sign) && (r_sign != a_sign);
            end
            OP_SUB, OP_CMP: begin
                {c_flag, res} = diff;
                // Unlike signs in, sign of a lost
                v_flag = (a_sign != b_sign) && (r_sign != a_sign);
            end
            OP_SHL: begin
                res    = a_i << b_i[SHAMT_W-1:0];
                c_flag = a_i[XLEN-1];
            end
            OP_SHR: begin
                // Logical, zero fill from the top
                res    = a_i >> b_i[SHAMT_W-1:0];
                c_flag = a_i[0];
            end
            OP_LDI: begin
                res = b_i;
            end
            default: begin
                // Unknown opcode, zero result
                res = '0;
            end
        endcase
    end

    assign y_o = res;

    assign flags_o = '{
        v: v_flag,
        n: r_sign,
        c: c_flag,
        z: (res == '0)
    };

endmodule

// File: alu/alu_stage.sv
module alu_stage (
    input  logic               clk_i,
    input  logic               rst_i,
    input  isa_pkg::issue_t    issue_i,
    output alu_pkg::wb_t       wb_o,
    output logic               wb_valid_o
);
    import alu_pkg::*;
    import isa_pkg::*;

    logic [XLEN-1:0] alu_y;
    flags_t          alu_flags;
    logic            carry_in;
    logic            op_writes;
    logic            op_known;

    // Registered result record
    logic            valid_q;
    logic            we_q;
    rd_idx_t         rd_q;
    logic [XLEN-1:0] data_q;
    flags_t          res_flags_q;

    // Flag register and pending flag update
    flags_t          flags_q;
    logic            flags_pend_q;

    // ------------------------------------------------------------------------
    // Execute
    // ------------------------------------------------------------------------

    // Record in flight is one cycle ahead of the flag register
    assign carry_in = flags_pend_q ? res_flags_q.c : flags_q.c;

    alu_core alu_core_i (
        .carry_i (carry_in),
        .op_i    (issue_i.op),
        .a_i     (issue_i.a),
        .b_i     (issue_i.b),
        .y_o     (alu_y),
        .flags_o (alu_flags)
    );

    // Opcode class
    always_comb begin
        case (issue_i.op)
            OP_ADD, OP_ADC, OP_SUB, OP_SHL, OP_SHR, OP_LDI: begin
                op_writes = 1'b1;
                op_known  = 1'b1;
            end
            OP_CMP: begin
                // Flags only
                op_writes = 1'b0;
                op_known  = 1'b1;
            end
            default: begin
                op_writes = 1'b0;
                op_known  = 1'b0;
            end
        endcase
    end

    // ------------------------------------------------------------------------
    // Result register and flag commit
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q      <= 1'b0;
            we_q         <= 1'b0;
            flags_pend_q <= 1'b0;
            flags_q      <= '0;
        end else begin
            valid_q      <= issue_i.valid;
            we_q         <= issue_i.valid && op_writes;
            flags_pend_q <= issue_i.valid && op_known;
            // Commit lands with the register write
            if (flags_pend_q) begin
                flags_q <= res_flags_q;
            end
        end
    end

    // Payload
    always_ff @(posedge clk_i) begin
        rd_q        <= issue_i.rd;
        data_q      <= alu_y;
        res_flags_q <= alu_flags;
    end

    assign wb_o = '{
        rd:    rd_q,
        we:    we_q,
        data:  data_q,
        flags: res_flags_q
    };

    assign wb_valid_o = valid_q;

endmodule

// File: src/exec_pipe_top.sv
module exec_pipe_top #(
    parameter int unsigned REG_COUNT = 8
) (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               instr_valid_i,
    input  isa_pkg::instr_t    instr_i,
    output logic               result_valid_o,
    output alu_pkg::wb_t       result_o
);
    import alu_pkg::*;
    import isa_pkg::*;

    issue_t               issue;
    wb_t                  wb;
    logic                 wb_valid;
    logic [REG_IDX_W-1:0] raddr_a;
    logic [REG_IDX_W-1:0] raddr_b;
    logic [XLEN-1:0]      rdata_a;
    logic [XLEN-1:0]      rdata_b;

    // Stage 1, operand fetch
    operand_fetch #(
        .REG_COUNT (REG_COUNT)
    ) operand_fetch_i (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .raddr_a_o     (raddr_a),
        .raddr_b_o     (raddr_b),
        .rdata_a_i     (rdata_a),
        .rdata_b_i     (rdata_b),
        .fwd_i         (wb),
        .issue_o       (issue)
    );

    // Stage 2, execute
    alu_stage alu_stage_i (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .issue_i    (issue),
        .wb_o       (wb),
        .wb_valid_o (wb_valid)
    );

    // Writeback target
    reg_file #(
        .REG_COUNT (REG_COUNT)
    ) reg_file_i (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .wb_i      (wb),
        .raddr_a_i (raddr_a),
        .raddr_b_i (raddr_b),
        .rdata_a_o (rdata_a),
        .rdata_b_o (rdata_b)
    );

    assign result_valid_o = wb_valid;
    assign result_o       = wb;

endmodule

// File: tb/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Columns: op, rd, rs1, rs2, use_imm, imm, exp we, exp data, exp flags VNCZ, gap
task automatic load_vectors();
    // Registers read zero out of reset
    add_row(OP_ADD, 1, 2, 3, 0, 16'h0000, 1, 16'h0000, 4'h1, 0);
    // Immediate load, then 7fff + 1 overflows into the sign bit
    add_row(OP_LDI, 1, 0, 0, 1, 16'h7fff, 1, 16'h7fff, 4'h0, 0);
    add_row(OP_ADD, 2, 1, 0, 1, 16'h0001, 1, 16'h8000, 4'hc, 0);
    add_row(OP_LDI, 3, 0, 0, 1, 16'hffff, 1, 16'hffff, 4'h4, 0);
    // Carry out of bit 15
    add_row(OP_ADD, 4, 3, 0, 1, 16'h0001, 1, 16'h0000, 4'h3, 0);
    // ADC right behind a carry adds 1, then behind no carry adds 0
    add_row(OP_ADC, 5, 2, 0, 1, 16'h0000, 1, 16'h8001, 4'h4, 0);
    add_row(OP_ADC, 6, 1, 0, 1, 16'h0000, 1, 16'h7fff, 4'h0, 0);
    // 8000 - 1 sets V
    add_row(OP_SUB, 7, 2, 0, 1, 16'h0001, 1, 16'h7fff, 4'h8, 0);
    add_row(OP_SUB, 1, 1, 0, 1, 16'h0002, 1, 16'h7ffd, 4'h0, 0);
    // Borrow, followed by idle cycles
    add_row(OP_SUB, 3, 0, 0, 1, 16'h0001, 1, 16'hffff, 4'h6, 1);
    // CMP equal, no write; r1 unchanged for the next read
    add_row(OP_CMP, 1, 1, 0, 1, 16'h7ffd, 0, 16'h0000, 4'h1, 0);
    add_row(OP_ADD, 2, 1, 0, 1, 16'h0000, 1, 16'h7ffd, 4'h0, 0);
    add_row(OP_CMP, 4, 2, 1, 0, 16'h0000, 0, 16'h0000, 4'h1, 0);
    // Shifts, C from a[15] or a[0]
    add_row(OP_LDI, 5, 0, 0, 1, 16'h8001, 1, 16'h8001, 4'h4, 0);
    add_row(OP_SHL, 6, 5, 0, 1, 16'h0001, 1, 16'h0002, 4'h2, 0);
    add_row(OP_SHR, 7, 5, 0, 1, 16'h0001, 1, 16'h4000, 4'h2, 0);
    add_row(OP_SHL, 6, 6, 0, 1, 16'h0004, 1, 16'h0020, 4'h0, 0);
    // Shift by zero returns a
    add_row(OP_SHR, 7, 7, 0, 1, 16'h0000, 1, 16'h4000, 4'h0, 0);
    add_row(OP_SHL, 3, 3, 0, 1, 16'h000f, 1, 16'h8000, 4'h6, 0);
    // 8000 + 8000, sets V C Z and leaves them committed
    add_row(OP_ADD, 4, 3, 0, 1, 16'h8000, 1, 16'h0000, 4'hb, 1);
    // Unknown opcode, zero result; ADC still sees the carry from before
    add_row(opcode_e'(4'hf), 5, 1, 2, 1, 16'h1234, 0, 16'h0000, 4'h1, 0);
    add_row(OP_ADC, 5, 0, 0, 1, 16'h0000, 1, 16'h0001, 4'h0, 0);
    // Both ports forwarded, then distance 1 and 2 together
    add_row(OP_ADD, 6, 5, 5, 0, 16'h0000, 1, 16'h0002, 4'h0, 0);
    add_row(OP_SUB, 0, 6, 5, 0, 16'h0000, 1, 16'h0001, 4'h0, 0);
endtask

`endif

// File: tb/tb_exec_pipe.sv
module tb_exec_pipe;
    import alu_pkg::*;
    import isa_pkg::*;

    localparam int CLK_PERIOD    = 4;
    localparam int DRIVE_DELAY   = 1;
    localparam int RESET_CYCLES  = 3;
    localparam int GAP_CYCLES    = 3;
    localparam int PULSE_TIMEOUT = 8;
    localparam int IDLE_CHECK    = 4;

    // One table row: instruction plus expected writeback
    typedef struct packed {
        instr_t               instr;
        logic [REG_IDX_W-1:0] exp_rd;
        logic                 exp_we;
        logic [XLEN-1:0]      exp_data;
        flags_t               exp_flags;
        logic                 gap;       // Idle cycles after this row
    } vec_t;

    logic   clk_i;
    logic   rst_i;
    logic   instr_valid_i;
    instr_t instr_i;
    logic   result_valid_o;
    wb_t    result_o;

    vec_t vectors [$];
    int   expected_cycle [$];
    int   num_rows    = 0;
    int   cycle_cnt   = 0;
    int   error_count = 0;
    int   pass_rows   = 0;
    int   fail_rows   = 0;

    exec_pipe_top #(
        .REG_COUNT (8)
    ) dut_i (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .result_valid_o (result_valid_o),
        .result_o       (result_o)
    );

    `include "tb_vectors.svh"

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // Rising edges seen so far
    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    function automatic void add_row(opcode_e op, int rd, int rs1, int rs2, int use_imm,
                                    logic [XLEN-1:0] imm, int exp_we,
                                    logic [XLEN-1:0] exp_data, logic [3:0] exp_flags,
                                    int gap);
        vec_t v;
        v.instr.op      = op;
        v.instr.rd      = REG_IDX_W'(rd);
        v.instr.rs1     = REG_IDX_W'(rs1);
        v.instr.rs2     = REG_IDX_W'(rs2);
        v.instr.use_imm = (use_imm != 0);
        v.instr.imm     = imm;
        // Result always names the instruction's rd
        v.exp_rd        = REG_IDX_W'(rd);
        v.exp_we        = (exp_we != 0);
        v.exp_data      = exp_data;
        v.exp_flags     = exp_flags;
        v.gap           = (gap != 0);
        vectors.push_back(v);
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s expected 0x%0h actual 0x%0h", name, expected, actual);
            error_count++;
        end
    endtask

    // ------------------------------------------------------------------------
    // Stimulus and collection
    // ------------------------------------------------------------------------
    task automatic drive_rows();
        for (int i = 0; i < num_rows; i++) begin
            @(posedge clk_i);
            #DRIVE_DELAY;
            instr_valid_i = 1'b1;
            instr_i       = vectors[i].instr;
            // Accepted at the next edge, result seen after the one after
            expected_cycle.push_back(cycle_cnt + 2);
            if (vectors[i].gap) begin
                @(posedge clk_i);
                #DRIVE_DELAY;
                instr_valid_i = 1'b0;
                repeat (GAP_CYCLES - 1) @(posedge clk_i);
            end
        end
        @(posedge clk_i);
        #DRIVE_DELAY;
        instr_valid_i = 1'b0;
    endtask

    task automatic collect_results();
        int   waited;
        int   errors_before;
        int   exp_cycle;
        vec_t row;
        for (int i = 0; i < num_rows; i++) begin
            row    = vectors[i];
            waited = 0;
            // Outputs sampled mid-cycle
            @(negedge clk_i);
            while (!result_valid_o && waited < PULSE_TIMEOUT) begin
                @(negedge clk_i);
                waited++;
            end
            if (!result_valid_o) begin
                $display("row %0d: no result pulse within %0d cycles", i, PULSE_TIMEOUT);
                error_count++;
                fail_rows += num_rows - i;
                break;
            end
            errors_before = error_count;
            exp_cycle = (expected_cycle.size() > 0) ? expected_cycle.pop_front() : -1;
            compare_value("result latency", exp_cycle, cycle_cnt);
            compare_value("result_o.rd", row.exp_rd, result_o.rd);
            compare_value("result_o.we", row.exp_we, result_o.we);
            compare_value("result_o.data", row.exp_data, result_o.data);
            compare_value("result_o.flags", row.exp_flags, result_o.flags);
            if (error_count == errors_before) begin
                pass_rows++;
            end else begin
                fail_rows++;
            end
            $display("row %2d op %h rd %0d: %s", i, row.instr.op, row.exp_rd,
                     (error_count == errors_before) ? "ok" : "mismatch");
        end
        // Nothing left in flight
        repeat (PULSE_TIMEOUT) begin
            @(negedge clk_i);
            if (result_valid_o) begin
                $display("extra result pulse with no instruction outstanding");
                error_count++;
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Main sequence and watchdog
    // ------------------------------------------------------------------------
    initial begin : main
        clk_i         = 1'b0;
        rst_i         = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        load_vectors();
        num_rows = vectors.size();
        repeat (RESET_CYCLES) @(posedge clk_i);
        #DRIVE_DELAY;
        rst_i = 1'b0;
        // Quiet pipeline out of reset
        repeat (IDLE_CHECK) begin
            @(negedge clk_i);
            if (result_valid_o) begin
                $display("result pulse seen after reset with no instruction issued");
                error_count++;
            end
        end
        fork
            drive_rows();
            collect_results();
        join
        $display("summary: %0d rows passed, %0d rows failed, %0d errors",
                 pass_rows, fail_rows, error_count);
        if (error_count == 0 && fail_rows == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        wait (num_rows > 0);
        #((num_rows + 20) * 4 * CLK_PERIOD);
        $display("watchdog expired before all rows completed");
        $display("TB FAILED");
        $finish;
    end

endmodule

// File: all.f
+incdir+tb
common/alu_pkg.sv
common/isa_pkg.sv
src/reg_file.sv
src/operand_fetch.sv
alu/alu_core.sv
alu/alu_stage.sv
src/exec_pipe_top.sv
tb/tb_exec_pipe.sv

// File: Makefile
TOP := tb_exec_pipe

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal -f all.f --top-module $(TOP) -Mdir obj_dir

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

lint:
	verilator --lint-only -Wall --timing -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir
